/* exec_units.f */
+incdir+design
+incdir+verif
design/exec_pkg.sv
design/int_alu.sv
design/mult_stage.sv
design/pipe_mult.sv
design/branch_unit.sv
design/exec_units.sv
verif/exec_units_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
  -f exec_units.f --top-module exec_units_tb -o exec_units_sim \
  && ./obj_dir/exec_units_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/exec_units_tests.svh */
task automatic alu_ops_test();
  int                     errs;
  word_t                  a;
  word_t                  b;
  logic [`IMM_WIDTH-1:0]  imm;
  word_t                  edge_a [6];
  word_t                  edge_b [6];
  logic [`IMM_WIDTH-1:0]  edge_imm [6];
  errs     = errors;
  // slot 0 is replaced by random values
  edge_a   = '{64'd0, 64'h8000_0000_0000_0001, '1, 64'h7fff_ffff_ffff_ffff, 64'h2a,
               64'hffff_ffff_ffff_ff00};
  edge_b   = '{64'd0, 64'd0, 64'd63, 64'h8000_0000_0000_0000, 64'h2a, 64'd5};
  edge_imm = '{8'd0, 8'd0, 8'd63, 8'hff, 8'h2a, 8'd5};
  for (int op = 0; op < 16; op++) begin
    for (int sel = 0; sel < 2; sel++) begin
      for (int n = 0; n < 6; n++) begin
        a   = (n == 0) ? {$urandom, $urandom} : edge_a[n];
        b   = (n == 0) ? {$urandom, $urandom} : edge_b[n];
        imm = (n == 0) ? `IMM_WIDTH'($urandom) : edge_imm[n];
        wait_drive_slot();
        alu_issue   = 1'b1;
        alu_grant   = 1'b1;
        alu_func    = alu_func_t'(op);
        alu_opb_sel = opb_sel_t'(sel);
        alu_opa     = a;
        alu_opb     = b;
        alu_imm     = imm;
        alu_tag     = pr_idx_t'($urandom);
        alu_rob_idx = rob_idx_t'($urandom);
        @(negedge clock);
        check_true(alu_done, "ALU did not signal done in the issue cycle");
        check_value("alu_result", alu_result,
                    alu_model(alu_func_t'(op), a, (sel == 1) ? word_t'(imm) : b));
        check_value("alu_tag_out", alu_tag_out, alu_tag);
        check_value("alu_rob_idx_out", alu_rob_idx_out, alu_rob_idx);
      end
    end
  end
  idle_cycles(1);
  report_test("alu_ops", errs);
endtask

task automatic drive_mult(input logic iss, input word_t a, input word_t b, input int k);
  mult_issue   = iss;
  mult_opa     = a;
  mult_opb     = b;
  mult_opb_sel = opb_sel_t'(k % 3 == 2);  // every third one takes the literal
  mult_imm     = b[`IMM_WIDTH-1:0];
  mult_tag     = pr_idx_t'(k + 1);
endtask

task automatic mult_throughput_test();
  int errs;
  bit acc;
  errs          = errors;
  check_latency = 1'b1;
  for (int k = 0; k < 8; k++) begin
    wait_drive_slot();
    mult_grant = 1'b1;
    drive_mult(1'b1, {$urandom, $urandom}, {$urandom, $urandom}, k);
    mult_rob_idx = rob_idx_t'(k);
    @(negedge clock);
    check_true(mult_free, "multiplier stalled with the grant held high");
    mult_scoreboard(acc);
  end
  idle_cycles(N + 3);
  check_true(exp_result.size() == 0, "multiplier lost results in the back-to-back stream");
  report_test("mult_throughput", errs);
endtask

task automatic mult_backpressure_test();
  int    errs;
  int    sent;
  bit    acc;
  bit    saw_full;
  word_t ops [24];  // a and b per multiply
  errs          = errors;
  sent          = 0;
  saw_full      = 1'b0;
  check_latency = 1'b0;
  for (int k = 0; k < 24; k++) begin
    ops[k] = {$urandom, $urandom};
  end
  for (int k = 0; k < 50 && (sent < 12 || exp_result.size() > 0); k++) begin
    wait_drive_slot();
    mult_grant = !(k >= 3 && k < 13);  // CDB busy for 10 cycles
    drive_mult(sent < 12, ops[2 * (sent % 12)], ops[2 * (sent % 12) + 1], sent);
    mult_rob_idx = rob_idx_t'(sent + 8);
    @(negedge clock);
    if (!mult_free) begin
      saw_full = 1'b1;
    end
    mult_scoreboard(acc);
    if (acc) begin
      sent++;
    end
  end
  idle_cycles(N + 3);
  check_true(sent == 12, "not every multiply was accepted");
  check_true(saw_full, "mult_free never fell while the pipeline was stalled");
  check_true(exp_result.size() == 0, "multiplier lost results under back-pressure");
  report_test("mult_backpressure", errs);
endtask

task automatic branch_test();
  int    errs;
  word_t opa_vals [6];
  errs     = errors;
  opa_vals = '{64'd0, 64'd1, 64'd2, '1, 64'h8000_0000_0000_0000, 64'h0123_4567_89ab_cdef};
  for (int f = 0; f < 8; f++) begin
    for (int v = 0; v < 6; v++) begin
      for (int m = 0; m < 3; m++) begin
        wait_drive_slot();
        br_issue    = 1'b1;
        br_func     = br_func_t'(f);
        br_cond     = (m == 0);
        br_uncond   = (m != 0);
        br_indirect = (m == 2);
        br_opa      = opa_vals[v];
        br_opb      = {$urandom, $urandom};
        br_npc      = {$urandom, $urandom};
        br_disp     = `BR_DISP_WIDTH'($urandom);
        br_rob_idx  = rob_idx_t'($urandom);
        @(negedge clock);
        check_true(br_done, "branch unit did not signal done in the issue cycle");
        check_value("br_rollback", br_rollback,
                    br_taken_model(br_func, br_cond, br_uncond, br_opa));
        check_value("br_target", br_target,
                    br_target_model(br_indirect, br_npc, br_opb, br_disp));
        check_value("br_rollback_rob_idx", br_rollback_rob_idx, br_rob_idx);
      end
    end
  end
  idle_cycles(1);
  report_test("branch", errs);
endtask

task automatic rollback_squash_test();
  int       errs;
  bit       acc;
  rob_idx_t robs [8];
  errs          = errors;
  check_latency = 1'b1;
  robs          = '{5'd4, 5'd12, 5'd25, 5'd10, 5'd2, 5'd18, 5'd31, 5'd11};
  for (int k = 0; k < N; k++) begin
    wait_drive_slot();
    mult_grant = 1'b1;
    rob_tail   = 5'd20;
    drive_mult(1'b1, {$urandom, $urandom}, {$urandom, $urandom}, k);
    mult_rob_idx = robs[k % 8];
    if (k == N - 1) begin  // branch at 10 lands with the last issue
      br_issue    = 1'b1;
      br_func     = 3'b000;
      br_cond     = 1'b0;
      br_uncond   = 1'b1;
      br_indirect = 1'b0;
      br_rob_idx  = 5'd10;
      alu_issue   = 1'b1;
      alu_grant   = 1'b0;  // squashed op frees the ALU anyway
      alu_rob_idx = 5'd14;
    end
    @(negedge clock);
    if (k == N - 1) begin
      check_value("alu_done", alu_done, 1'b0);
      check_value("alu_free", alu_free, 1'b1);
    end
    mult_scoreboard(acc);
  end
  idle_cycles(N + 3);
  check_true(exp_result.size() == 0, "a multiply that survived the branch never completed");
  report_test("rollback_squash", errs);
endtask

/* verif/exec_units_tb.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_units_tb
  import exec_pkg::*;
();

  localparam int N     = `NUM_MULT_STAGES;
  localparam int LIMIT = 2000;  // the five tests need about 450 cycles

  logic                       clock, reset;
  rob_idx_t                   rob_tail;
  logic                       alu_issue, alu_grant, alu_done, alu_free;
  logic                       mult_issue, mult_grant, mult_done, mult_free;
  logic                       br_issue, br_cond, br_uncond, br_indirect, br_done, br_rollback;
  alu_func_t                  alu_func;
  opb_sel_t                   alu_opb_sel, mult_opb_sel;
  word_t                      alu_opa, alu_opb, alu_result, mult_opa, mult_opb, mult_result;
  word_t                      br_npc, br_opa, br_opb, br_target;
  logic [`IMM_WIDTH-1:0]      alu_imm, mult_imm;
  logic [`BR_DISP_WIDTH-1:0]  br_disp;
  pr_idx_t                    alu_tag, alu_tag_out, mult_tag, mult_tag_out;
  rob_idx_t                   alu_rob_idx, alu_rob_idx_out, mult_rob_idx, mult_rob_idx_out;
  rob_idx_t                   br_rob_idx, br_rollback_rob_idx;
  br_func_t                   br_func;

  int        cycle_count = 0;
  int        checks = 0;
  int        errors = 0;
  int        tests_failed = 0;
  bit        check_latency;
  // multiplier results still owed, oldest first
  word_t     exp_result[$];
  pr_idx_t   exp_tag[$];
  rob_idx_t  exp_rob[$];
  int        exp_cycle[$];

  exec_units i_dut (.*);

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  function automatic word_t alu_model(input alu_func_t f, input word_t a, input word_t b);
    int sh;
    sh = int'(b % `WORD_WIDTH);
    case (f)
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_AND:    return a & b;
      ALU_BIC:    return a & ~b;
      ALU_OR:     return a | b;
      ALU_ORNOT:  return a | ~b;
      ALU_XOR:    return a ^ b;
      ALU_EQV:    return ~(a ^ b);
      ALU_SRL:    return a >> sh;
      ALU_SLL:    return a << sh;
      ALU_SRA:    return (a >> sh) | (a[`WORD_WIDTH-1] ? ~(~word_t'(0) >> sh) : word_t'(0));
      ALU_CMPULT: return word_t'(a < b);
      ALU_CMPULE: return word_t'(a <= b);
      ALU_CMPLT:  return word_t'($signed(a) < $signed(b));
      ALU_CMPLE:  return word_t'($signed(a) <= $signed(b));
      default:    return a * b;
    endcase
  endfunction

  // age window from the branch up to the tail, with wrap
  function automatic logic in_squash_window(input rob_idx_t entry, input rob_idx_t br,
                                            input rob_idx_t tail);
    int d_entry;
    int d_tail;
    d_entry = (int'(entry) - int'(br) + `ROB_DEPTH) % `ROB_DEPTH;
    d_tail  = (int'(tail) - int'(br) + `ROB_DEPTH) % `ROB_DEPTH;
    return d_entry <= d_tail;
  endfunction

  function automatic logic br_taken_model(input br_func_t f, input logic c, input logic u,
                                          input word_t a);
    logic hit;
    case (f[1:0])
      2'd0:    hit = (a[0] == 1'b0);
      2'd1:    hit = (a == 0);
      2'd2:    hit = ($signed(a) < 0);
      default: hit = ($signed(a) <= 0);
    endcase
    return u || (c && (hit ^ f[2]));
  endfunction

  function automatic word_t br_target_model(input logic ind, input word_t npc, input word_t b,
                                            input logic [`BR_DISP_WIDTH-1:0] d);
    word_t offset;
    offset = {{(`WORD_WIDTH-`BR_DISP_WIDTH){d[`BR_DISP_WIDTH-1]}}, d};
    return ind ? (b & ~word_t'(3)) : npc + (offset << 2);
  endfunction

  task automatic wait_drive_slot();
    @(posedge clock);
    #2;
  endtask

  // called at the falling edge, inputs and outputs both settled
  task automatic mult_scoreboard(output bit accepted);
    logic  kill;
    int    c0;
    word_t b_val;
    kill = br_issue && br_taken_model(br_func, br_cond, br_uncond, br_opa);
    if (mult_done && mult_grant) begin
      if (exp_result.size() == 0) begin
        check_true(1'b0, "multiplier produced a result that was not expected");
      end else begin
        check_value("mult_result", mult_result, exp_result.pop_front());
        check_value("mult_tag_out", mult_tag_out, exp_tag.pop_front());
        check_value("mult_rob_idx_out", mult_rob_idx_out, exp_rob.pop_front());
        c0 = exp_cycle.pop_front();
        if (check_latency) begin
          check_true(cycle_count - c0 == N, "multiplier result arrived at the wrong cycle");
        end
      end
    end
    for (int k = exp_rob.size() - 1; k >= 0; k--) begin
      if (kill && in_squash_window(exp_rob[k], br_rob_idx, rob_tail)) begin
        exp_result.delete(k);
        exp_tag.delete(k);
        exp_rob.delete(k);
        exp_cycle.delete(k);
      end
    end
    accepted = mult_issue && mult_free;
    if (accepted && !(kill && in_squash_window(mult_rob_idx, br_rob_idx, rob_tail))) begin
      b_val = (mult_opb_sel == OPB_IS_IMM) ? word_t'(mult_imm) : mult_opb;
      exp_result.push_back(mult_opa * b_val);
      exp_tag.push_back(mult_tag);
      exp_rob.push_back(mult_rob_idx);
      exp_cycle.push_back(cycle_count);
    end
  endtask

  task automatic idle_cycles(input int n);
    bit acc;
    repeat (n) begin
      wait_drive_slot();
      alu_issue  = 1'b0;
      mult_issue = 1'b0;
      br_issue   = 1'b0;
      mult_grant = 1'b1;
      @(negedge clock);
      mult_scoreboard(acc);
    end
  endtask

  `include "exec_units_tests.svh"

  initial begin
    void'($urandom(32'ha2547778));
    clock        = 1'b0;
    reset        = 1'b1;
    rob_tail     = '0;
    alu_func     = ALU_ADD;
    alu_opb_sel  = OPB_IS_REG;
    mult_opb_sel = OPB_IS_REG;
    {alu_issue, alu_grant, alu_opa, alu_opb, alu_imm, alu_tag, alu_rob_idx} = '0;
    {mult_issue, mult_grant, mult_opa, mult_opb, mult_imm, mult_tag, mult_rob_idx} = '0;
    {br_issue, br_func, br_cond, br_uncond, br_indirect} = '0;
    {br_npc, br_opa, br_opb, br_disp, br_rob_idx} = '0;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    @(negedge clock);
    check_true(!alu_done && !mult_done && !br_rollback && alu_free && mult_free,
               "units are not idle after reset");
    alu_ops_test();
    mult_throughput_test();
    mult_backpressure_test();
    branch_test();
    rollback_squash_test();
    $display("tests run: 5, failed: %0d, checks: %0d, errors: %0d",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* design/exec_units.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_units
  import exec_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  rob_idx_t                   rob_tail,

  input  logic                       alu_issue,
  input  alu_func_t                  alu_func,
  input  opb_sel_t                   alu_opb_sel,
  input  word_t                      alu_opa,
  input  word_t                      alu_opb,
  input  logic [`IMM_WIDTH-1:0]      alu_imm,
  input  pr_idx_t                    alu_tag,
  input  rob_idx_t                   alu_rob_idx,
  input  logic                       alu_grant,
  output logic                       alu_done,
  output word_t                      alu_result,
  output pr_idx_t                    alu_tag_out,
  output rob_idx_t                   alu_rob_idx_out,
  output logic                       alu_free,

  input  logic                       mult_issue,
  input  opb_sel_t                   mult_opb_sel,
  input  word_t                      mult_opa,
  input  word_t                      mult_opb,
  input  logic [`IMM_WIDTH-1:0]      mult_imm,
  input  pr_idx_t                    mult_tag,
  input  rob_idx_t                   mult_rob_idx,
  input  logic                       mult_grant,
  output logic                       mult_done,
  output word_t                      mult_result,
  output pr_idx_t                    mult_tag_out,
  output rob_idx_t                   mult_rob_idx_out,
  output logic                       mult_free,

  input  logic                       br_issue,
  input  br_func_t                   br_func,
  input  logic                       br_cond,
  input  logic                       br_uncond,
  input  logic                       br_indirect,
  input  word_t                      br_npc,
  input  word_t                      br_opa,
  input  word_t                      br_opb,
  input  logic [`BR_DISP_WIDTH-1:0]  br_disp,
  input  rob_idx_t                   br_rob_idx,
  output logic                       br_done,
  output word_t                      br_target,
  output logic                       br_rollback,
  output rob_idx_t                   br_rollback_rob_idx
);

  int_alu u_alu (
    .clock            (clock),
    .reset            (reset),
    .issue            (alu_issue),
    .func             (alu_func),
    .opb_sel          (alu_opb_sel),
    .opa              (alu_opa),
    .opb              (alu_opb),
    .imm              (alu_imm),
    .tag              (alu_tag),
    .rob_idx          (alu_rob_idx),
    .grant            (alu_grant),
    .rollback         (br_rollback),
    .rollback_rob_idx (br_rollback_rob_idx),
    .rob_tail         (rob_tail),
    .done             (alu_done),
    .result           (alu_result),
    .tag_out          (alu_tag_out),
    .rob_idx_out      (alu_rob_idx_out),
    .free             (alu_free)
  );

  pipe_mult u_mult (
    .clock            (clock),
    .reset            (reset),
    .issue            (mult_issue),
    .opb_sel          (mult_opb_sel),
    .opa              (mult_opa),
    .opb              (mult_opb),
    .imm              (mult_imm),
    .tag              (mult_tag),
    .rob_idx          (mult_rob_idx),
    .grant            (mult_grant),
    .rollback         (br_rollback),
    .rollback_rob_idx (br_rollback_rob_idx),
    .rob_tail         (rob_tail),
    .done             (mult_done),
    .result           (mult_result),
    .tag_out          (mult_tag_out),
    .rob_idx_out      (mult_rob_idx_out),
    .free             (mult_free)
  );

  // rollback comes straight out of here, same cycle
  branch_unit u_br (
    .clock            (clock),
    .reset            (reset),
    .issue            (br_issue),
    .func             (br_func),
    .cond             (br_cond),
    .uncond           (br_uncond),
    .indirect         (br_indirect),
    .npc              (br_npc),
    .opa              (br_opa),
    .opb              (br_opb),
    .disp             (br_disp),
    .rob_idx          (br_rob_idx),
    .done             (br_done),
    .target           (br_target),
    .rollback         (br_rollback),
    .rollback_rob_idx (br_rollback_rob_idx)
  );

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module branch_unit
  import exec_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       issue,
  input  br_func_t                   func,
  input  logic                       cond,
  input  logic                       uncond,
  input  logic                       indirect,
  input  word_t                      npc,
  input  word_t                      opa,
  input  word_t                      opb,
  input  logic [`BR_DISP_WIDTH-1:0]  disp,
  input  rob_idx_t                   rob_idx,
  output logic                       done,
  output word_t                      target,
  output logic                       rollback,
  output rob_idx_t                   rollback_rob_idx
);

  localparam int MSB = `WORD_WIDTH - 1;

  logic   cond_true;
  logic   taken;
  word_t  disp_ext;

  always_comb begin
    case (func[1:0])
      2'b00:   cond_true = !opa[0];              // low bit clear
      2'b01:   cond_true = opa == '0;
      2'b10:   cond_true = opa[MSB];             // negative
      default: cond_true = opa[MSB] || (opa == '0);
    endcase
    if (func[2]) begin
      cond_true = !cond_true;
    end
  end

  assign taken = uncond || (cond && cond_true);

  // word displacement to byte offset
  assign disp_ext = {{(`WORD_WIDTH-`BR_DISP_WIDTH-2){disp[`BR_DISP_WIDTH-1]}},
                     disp, 2'b00};

  assign target = indirect ? {opb[MSB:2], 2'b00} : npc + disp_ext;

  assign done             = issue;
  assign rollback         = issue && taken;
  assign rollback_rob_idx = rob_idx;

  // fetch is redirected on rollback, target must be resolved
  a_rollback_target_known: assert property (
    @(posedge clock) disable iff (reset) rollback |-> !$isunknown(target)
  );

endmodule

/* design/pipe_mult.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module pipe_mult
  import exec_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   issue,
  input  opb_sel_t               opb_sel,
  input  word_t                  opa,
  input  word_t                  opb,
  input  logic [`IMM_WIDTH-1:0]  imm,
  input  pr_idx_t                tag,
  input  rob_idx_t               rob_idx,
  input  logic                   grant,
  input  logic                   rollback,
  input  rob_idx_t               rollback_rob_idx,
  input  rob_idx_t               rob_tail,
  output logic                   done,
  output word_t                  result,
  output pr_idx_t                tag_out,
  output rob_idx_t               rob_idx_out,
  output logic                   free
);

  localparam int N = `NUM_MULT_STAGES;

  // index 0 is the issue side, index i+1 the output of stage i
  word_t     product [N+1];
  word_t     mplier  [N+1];
  word_t     mcand   [N+1];
  pr_idx_t   tags    [N+1];
  rob_idx_t  robs    [N+1];
  logic [N-1:0]  full;
  logic [N-1:0]  load;
  logic [N-1:0]  hold;

  assign product[0] = '0;
  assign mplier[0]  = opa;
  assign mcand[0]   = (opb_sel == OPB_IS_IMM) ?
                      {{(`WORD_WIDTH-`IMM_WIDTH){1'b0}}, imm} : opb;
  assign tags[0]    = tag;
  assign robs[0]    = rob_idx;

  // stall ripples back from the CDB
  always_comb begin
    hold[N-1] = full[N-1] && !grant;
    for (int k = N - 2; k >= 0; k--) begin
      hold[k] = full[k] && hold[k+1];
    end
  end

  always_comb begin
    load[0] = issue && !hold[0];
    for (int k = 1; k < N; k++) begin
      load[k] = full[k-1] && !hold[k-1];
    end
  end

  genvar i;
  generate
    for (i = 0; i < N; i++) begin : g_stage
      mult_stage u_stage (
        .clock            (clock),
        .reset            (reset),
        .load             (load[i]),
        .hold             (hold[i]),
        .product_in       (product[i]),
        .mplier_in        (mplier[i]),
        .mcand_in         (mcand[i]),
        .tag              (tags[i]),
        .rob_idx          (robs[i]),
        .rollback         (rollback),
        .rollback_rob_idx (rollback_rob_idx),
        .rob_tail         (rob_tail),
        .full             (full[i]),
        .product_out      (product[i+1]),
        .mplier_out       (mplier[i+1]),
        .mcand_out        (mcand[i+1]),
        .tag_out          (tags[i+1]),
        .rob_idx_out      (robs[i+1])
      );
    end
  endgenerate

  assign done        = full[N-1];
  assign result      = product[N];
  assign tag_out     = tags[N];
  assign rob_idx_out = robs[N];
  assign free        = !hold[0];

  a_result_held: assert property (
    @(posedge clock) disable iff (reset)
    done && !grant && !rollback |=> done && $stable(result) && $stable(tag_out)
  );

endmodule

/* design/mult_stage.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module mult_stage
  import exec_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      load,
  input  logic      hold,
  input  word_t     product_in,
  input  word_t     mplier_in,
  input  word_t     mcand_in,
  input  pr_idx_t   tag,
  input  rob_idx_t  rob_idx,
  input  logic      rollback,
  input  rob_idx_t  rollback_rob_idx,
  input  rob_idx_t  rob_tail,
  output logic      full,
  output word_t     product_out,
  output word_t     mplier_out,
  output word_t     mcand_out,
  output pr_idx_t   tag_out,
  output rob_idx_t  rob_idx_out
);

  localparam int SLICE = `WORD_WIDTH / `NUM_MULT_STAGES;

  word_t  partial;
  word_t  next_product;
  word_t  next_mplier;
  word_t  next_mcand;
  logic   squash_in;
  logic   squash_held;

  // one slice of the multiplier per stage
  assign partial      = mplier_in[SLICE-1:0] * mcand_in;
  assign next_product = product_in + partial;
  assign next_mplier  = mplier_in >> SLICE;
  assign next_mcand   = mcand_in << SLICE;

  assign squash_in   = rollback && is_squashed(rob_idx, rollback_rob_idx, rob_tail);
  assign squash_held = rollback && is_squashed(rob_idx_out, rollback_rob_idx, rob_tail);

  always_ff @(posedge clock) begin
    if (reset) begin
      full <= 1'b0;
    end else if (hold) begin
      full <= full && !squash_held;  // stalled entry can still be killed
    end else begin
      full <= load && !squash_in;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      product_out <= next_product;
      mplier_out  <= next_mplier;
      mcand_out   <= next_mcand;
      tag_out     <= tag;
      rob_idx_out <= rob_idx;
    end
  end

  // a stalled entry stays put unless a branch kills it
  a_hold_keeps_entry: assert property (
    @(posedge clock) disable iff (reset)
    full && hold && !rollback |=> full && $stable(rob_idx_out) && $stable(product_out)
  );

endmodule

/* design/int_alu.sv */
`timescale 1ns/1ps
`include "exec_defs.svh"

module int_alu
  import exec_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   issue,
  input  alu_func_t              func,
  input  opb_sel_t               opb_sel,
  input  word_t                  opa,
  input  word_t                  opb,
  input  logic [`IMM_WIDTH-1:0]  imm,
  input  pr_idx_t                tag,
  input  rob_idx_t               rob_idx,
  input  logic                   grant,
  input  logic                   rollback,
  input  rob_idx_t               rollback_rob_idx,
  input  rob_idx_t               rob_tail,
  output logic                   done,
  output word_t                  result,
  output pr_idx_t                tag_out,
  output rob_idx_t               rob_idx_out,
  output logic                   free
);

  localparam int MSB     = `WORD_WIDTH - 1;
  localparam int SHAMT_W = $clog2(`WORD_WIDTH);

  word_t               opb_val;
  logic [SHAMT_W-1:0]  shamt;
  logic                squash;
  logic                signed_lt;
  logic                unsigned_lt;
  logic                equal;

  assign opb_val = (opb_sel == OPB_IS_IMM) ?
                   {{(`WORD_WIDTH-`IMM_WIDTH){1'b0}}, imm} : opb;
  assign shamt   = opb_val[SHAMT_W-1:0];

  assign unsigned_lt = opa < opb_val;
  assign equal       = opa == opb_val;
  // same sign: plain compare works; else the negative one is smaller
  assign signed_lt   = (opa[MSB] == opb_val[MSB]) ? unsigned_lt : opa[MSB];

  always_comb begin
    case (func)
      ALU_ADD:    result = opa + opb_val;
      ALU_SUB:    result = opa - opb_val;
      ALU_AND:    result = opa & opb_val;
      ALU_BIC:    result = opa & ~opb_val;
      ALU_OR:     result = opa | opb_val;
      ALU_ORNOT:  result = opa | ~opb_val;
      ALU_XOR:    result = opa ^ opb_val;
      ALU_EQV:    result = opa ^ ~opb_val;
      ALU_SRL:    result = opa >> shamt;
      ALU_SLL:    result = opa << shamt;
      ALU_SRA:    result = $signed(opa) >>> shamt;
      ALU_CMPULT: result = {{MSB{1'b0}}, unsigned_lt};
      ALU_CMPULE: result = {{MSB{1'b0}}, unsigned_lt || equal};
      ALU_CMPLT:  result = {{MSB{1'b0}}, signed_lt};
      ALU_CMPLE:  result = {{MSB{1'b0}}, signed_lt || equal};
      ALU_MUL:    result = opa * opb_val;  // low word only
      default:    result = '0;
    endcase
  end

  assign squash = rollback && is_squashed(rob_idx, rollback_rob_idx, rob_tail);

  assign done        = issue && !squash;
  assign tag_out     = tag;
  assign rob_idx_out = rob_idx;
  // issuer holds operands until the CDB takes the result
  assign free        = grant || !issue || squash;

  // result is combinational, a stalled op needs its operands kept
  a_held_until_grant: assert property (
    @(posedge clock) disable iff (reset)
    done && !grant |=> squash || (done && $stable(result) && $stable(tag_out))
  );

endmodule

/* design/exec_pkg.sv */
`include "exec_defs.svh"

package exec_pkg;

  typedef logic [`WORD_WIDTH-1:0]         word_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0]  rob_idx_t;
  typedef logic [$clog2(`PR_COUNT)-1:0]   pr_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_BIC,     // a & ~b
    ALU_OR,
    ALU_ORNOT,
    ALU_XOR,
    ALU_EQV,     // a ^ ~b
    ALU_SRL,
    ALU_SLL,
    ALU_SRA,
    ALU_CMPULT,
    ALU_CMPULE,
    ALU_CMPLT,
    ALU_CMPLE,
    ALU_MUL
  } alu_func_t;

  typedef enum logic {
    OPB_IS_REG,
    OPB_IS_IMM
  } opb_sel_t;

  // [1:0] picks the test, [2] inverts it
  typedef logic [2:0] br_func_t;

  // entry is as old as the branch or younger, up to the tail
  function automatic logic is_squashed(input rob_idx_t entry,
                                       input rob_idx_t br_idx,
                                       input rob_idx_t tail);
    rob_idx_t entry_dist;
    rob_idx_t tail_dist;
    entry_dist = entry - br_idx;  // modular
    tail_dist  = tail - br_idx;
    return entry_dist <= tail_dist;
  endfunction

endpackage

/* design/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// datapath
`define WORD_WIDTH 64

// reorder buffer entries, power of two so indices wrap
`define ROB_DEPTH 32

// physical register file
`define PR_COUNT 64

// multiplier pipeline depth
// must divide WORD_WIDTH evenly (2, 4 or 8)
`define NUM_MULT_STAGES 4

// zero-extended ALU literal
`define IMM_WIDTH 8

// branch displacement in instruction words
`define BR_DISP_WIDTH 21

`endif
